// ==== Bender.yml ====
package:
  name: fetch_unit

sources:
  - hdl/fetch_pkg.sv
  - hdl/fetch_imem.sv
  - hdl/fetch_halfword_fifo.sv
  - hdl/fetch_ctrl_regs.sv
  - hdl/fetch_stage.sv
  - hdl/fetch_top.sv
  - target: test
    files:
      - test/fetch_clk_gen.sv
      - test/fetch_tb.sv

// ==== fetch_unit.f ====
hdl/fetch_pkg.sv
hdl/fetch_imem.sv
hdl/fetch_halfword_fifo.sv
hdl/fetch_ctrl_regs.sv
hdl/fetch_stage.sv
hdl/fetch_top.sv
test/fetch_clk_gen.sv
test/fetch_tb.sv

// ==== hdl/fetch_ctrl_regs.sv ====
module fetch_ctrl_regs (
    input  logic                 clk,
    input  logic                 reset_i,
    input  fetch_pkg::wb_m2s_t   wb_i,
    output fetch_pkg::wb_s2m_t   wb_o,
    input  logic [2:0]           fill_i,
    output fetch_pkg::imem_wr_t  imem_wr_o,
    output logic                 run_o,
    output logic [31:0]          boot_pc_o
);

    // ==============================
    // wishbone handshake
    // ==============================
    logic ack_q;
    // set once acked, cleared when stb drops
    logic done_q;
    logic access;
    logic reg_space;
    logic run_q;
    logic [31:0] boot_pc_q;
    logic [31:0] rdat_q;
    fetch_pkg::wb_reg_e reg_sel;

    // one access per strobe
    assign access    = wb_i.cyc && wb_i.stb && !done_q;
    assign reg_space = wb_i.adr[fetch_pkg::WB_REG_SPACE];
    assign reg_sel   = fetch_pkg::wb_reg_e'(wb_i.adr[3:2]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            ack_q  <= access;
            done_q <= (wb_i.cyc && wb_i.stb) ? (done_q | access) : 1'b0;
        end
    end

    // ==============================
    // registers
    // ==============================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q     <= 1'b0;
            boot_pc_q <= '0;
        end else if (access && wb_i.we && reg_space) begin
            case (reg_sel)
                fetch_pkg::REG_CTRL: begin
                    if (wb_i.sel[0]) begin
                        run_q <= wb_i.dat[0];
                    end
                end
                fetch_pkg::REG_BOOT_PC: begin
                    for (int b = 0; b < 4; b++) begin
                        if (wb_i.sel[b]) begin
                            boot_pc_q[b*8 +: 8] <= wb_i.dat[b*8 +: 8];
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // read data, memory window reads as zero
    always_ff @(posedge clk) begin
        if (access) begin
            rdat_q <= '0;
            if (reg_space) begin
                case (reg_sel)
                    fetch_pkg::REG_CTRL:    rdat_q <= {31'd0, run_q};
                    fetch_pkg::REG_BOOT_PC: rdat_q <= boot_pc_q;
                    // running plus fifo fill
                    fetch_pkg::REG_STATUS:  rdat_q <= {28'd0, fill_i, run_q};
                    default:                rdat_q <= '0;
                endcase
            end
        end
    end

    // ==============================
    // memory load window
    // ==============================
    // memory writes at the same edge as the ack
    assign imem_wr_o.en   = access && wb_i.we && !reg_space;
    assign imem_wr_o.addr = wb_i.adr[fetch_pkg::IMEM_AW+1:2];
    assign imem_wr_o.be   = wb_i.sel;
    assign imem_wr_o.data = wb_i.dat;

    assign wb_o.ack  = ack_q;
    assign wb_o.dat  = rdat_q;
    assign run_o     = run_q;
    assign boot_pc_o = boot_pc_q;

endmodule

// ==== hdl/fetch_halfword_fifo.sv ====
module fetch_halfword_fifo (
    input  logic                          clk,
    input  logic                          reset_i,
    input  fetch_pkg::redirect_t          redirect_i,
    input  logic [1:0]                    drain_i,
    output logic                          mem_rd_en_o,
    output logic [fetch_pkg::IMEM_AW-1:0] mem_addr_o,
    input  logic [31:0]                   mem_data_i,
    output logic [31:0]                   head_o,
    output logic [2:0]                    count_o,
    output logic [31:0]                   head_pc_o
);

    // ==============================
    // state
    // ==============================
    // slot 0 is the oldest halfword
    logic [15:0] slot_q [fetch_pkg::FIFO_SLOTS];
    logic [15:0] slot_d [fetch_pkg::FIFO_SLOTS];
    logic [2:0] count_q;
    logic [2:0] count_d;
    // halfwords left after this cycle's drain
    logic [2:0] kept;
    // a word read is on its way back from memory
    logic inflight_q;
    // the read on its way only brings its upper halfword
    logic skip_q;
    fetch_pkg::fifo_state_e state_q;
    logic [fetch_pkg::IMEM_AW-1:0] word_addr_q;
    logic [31:0] head_pc_q;
    logic [15:0] in_lo;
    logic [2:0] n_in;
    logic rd_en;

    // ==============================
    // next slot contents
    // ==============================
    always_comb begin
        kept = count_q - {1'b0, drain_i};

        // issue when free slots after drain, less two for a pending read, are >= 2
        rd_en = (state_q != fetch_pkg::FILL_IDLE) && !redirect_i.valid &&
                (({1'b0, kept} + (inflight_q ? 4'd2 : 4'd0)) <=
                 4'(fetch_pkg::FIFO_SLOTS - 2));

        // first word after an odd target, low half is dropped
        in_lo = skip_q ? mem_data_i[31:16] : mem_data_i[15:0];
        n_in  = inflight_q ? (skip_q ? 3'd1 : 3'd2) : 3'd0;

        // shift out drained halfwords
        for (int i = 0; i < fetch_pkg::FIFO_SLOTS; i++) begin
            if (i + int'(drain_i) < fetch_pkg::FIFO_SLOTS) begin
                slot_d[i] = slot_q[i + int'(drain_i)];
            end else begin
                slot_d[i] = slot_q[i];
            end
        end

        // append arriving halfwords behind the kept ones
        if (inflight_q) begin
            for (int i = 0; i < fetch_pkg::FIFO_SLOTS; i++) begin
                if (i == int'(kept)) begin
                    slot_d[i] = in_lo;
                end else if (!skip_q && i == int'(kept) + 1) begin
                    slot_d[i] = mem_data_i[31:16];
                end
            end
        end

        count_d = kept + n_in;
    end

    // ==============================
    // control registers
    // ==============================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count_q     <= '0;
            inflight_q  <= 1'b0;
            skip_q      <= 1'b0;
            state_q     <= fetch_pkg::FILL_IDLE;
            word_addr_q <= '0;
            head_pc_q   <= '0;
        end else if (redirect_i.valid) begin
            // drop everything, including a read in flight
            count_q     <= '0;
            inflight_q  <= 1'b0;
            skip_q      <= 1'b0;
            word_addr_q <= redirect_i.pc[fetch_pkg::IMEM_AW+1:2];
            head_pc_q   <= {redirect_i.pc[31:1], 1'b0};
            // odd halfword target
            state_q     <= redirect_i.pc[1] ? fetch_pkg::FILL_SKIP_HI : fetch_pkg::FILL_RUN;
        end else begin
            count_q    <= count_d;
            inflight_q <= rd_en;
            head_pc_q  <= head_pc_q + {29'd0, drain_i, 1'b0};
            if (rd_en) begin
                skip_q      <= (state_q == fetch_pkg::FILL_SKIP_HI);
                word_addr_q <= word_addr_q + 1'b1;
                // only the first word after the redirect is trimmed
                if (state_q == fetch_pkg::FILL_SKIP_HI) begin
                    state_q <= fetch_pkg::FILL_RUN;
                end
            end
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        slot_q <= slot_d;
    end

    // ==============================
    // outputs
    // ==============================
    assign mem_rd_en_o = rd_en;
    assign mem_addr_o  = word_addr_q;
    assign head_o      = {slot_q[1], slot_q[0]};
    assign count_o     = count_q;
    assign head_pc_o   = head_pc_q;

endmodule

// ==== hdl/fetch_imem.sv ====
module fetch_imem (
    input  logic                         clk,
    input  logic                         rd_en_i,
    input  logic [fetch_pkg::IMEM_AW-1:0] rd_addr_i,
    output logic [31:0]                  rd_data_o,
    input  fetch_pkg::imem_wr_t          wr_i
);

    // ==============================
    // storage
    // ==============================
    // one word per entry, inferred block ram
    logic [31:0] mem [2**fetch_pkg::IMEM_AW];

    // loader side, per byte lanes
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_i.be[b]) begin
                    mem[wr_i.addr][b*8 +: 8] <= wr_i.data[b*8 +: 8];
                end
            end
        end
    end

    // ==============================
    // fetch read port
    // ==============================
    // registered output, data one cycle after rd_en
    // holds last word when no read
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

    // ==============================
    // sizes and constants
    // ==============================
    // word address width of the instruction memory, 1024 words
    localparam int IMEM_AW = 10;
    // halfword slots in the fetch queue
    localparam int FIFO_SLOTS = 5;
    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;
    // byte address bit, set for registers, clear for memory window
    localparam int WB_REG_SPACE = 12;

    // ==============================
    // enums
    // ==============================
    // register word offsets, taken from adr[3:2]
    typedef enum logic [1:0] {
        REG_CTRL    = 2'd0,
        REG_BOOT_PC = 2'd1,
        REG_STATUS  = 2'd2
    } wb_reg_e;

    // fill control of the halfword queue
    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_RUN,
        FILL_SKIP_HI
    } fifo_state_e;

    // ==============================
    // bundles
    // ==============================
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_m2s_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_t;

    // branch target or run start target
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    // loader write port, be is the byte mask from sel
    typedef struct packed {
        logic               en;
        logic [IMEM_AW-1:0] addr;
        logic [3:0]         be;
        logic [31:0]        data;
    } imem_wr_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        compressed;
    } fetch_out_t;

endpackage

// ==== hdl/fetch_stage.sv ====
module fetch_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   run_i,
    input  logic [31:0]            boot_pc_i,
    input  logic                   enable_i,
    input  logic                   flush_i,
    input  fetch_pkg::redirect_t   branch_i,
    input  logic [31:0]            head_i,
    input  logic [2:0]             count_i,
    input  logic [31:0]            head_pc_i,
    output fetch_pkg::redirect_t   redirect_o,
    output logic [1:0]             drain_o,
    output fetch_pkg::fetch_out_t  out_o
);

    logic run_q;
    logic start;
    logic is_c;
    // a whole instruction sits at the head
    logic have;

    // run edge detect
    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= run_i;
        end
    end

    // ==============================
    // redirect
    // ==============================
    // run start wins over a branch in the same cycle
    assign start            = run_i && !run_q;
    assign redirect_o.valid = start || (branch_i.valid && run_q);
    assign redirect_o.pc    = start ? boot_pc_i : branch_i.pc;

    // ==============================
    // instruction and drain
    // ==============================
    // low bits 11 mark a 32 bit instruction
    assign is_c = (head_i[1:0] != 2'b11);
    assign have = run_q && ((count_i >= 3'd2) || (count_i == 3'd1 && is_c));

    always_comb begin
        out_o.pc         = head_pc_i;
        out_o.compressed = is_c;
        out_o.instr      = is_c ? {16'd0, head_i[15:0]} : head_i;
        out_o.valid      = have && !redirect_o.valid;
        drain_o          = 2'd0;
        if (redirect_o.valid) begin
            // branch takes the cycle, no output
            out_o.valid = 1'b0;
        end else if (flush_i) begin
            // bubble into decode, queue untouched
            out_o.valid      = run_q;
            out_o.instr      = fetch_pkg::NOP_INSTR;
            out_o.compressed = 1'b0;
        end else if (enable_i && have) begin
            drain_o = is_c ? 2'd1 : 2'd2;
        end
    end

endmodule

// ==== hdl/fetch_top.sv ====
module fetch_top (
    input  logic                   clk,
    input  logic                   reset_i,
    input  fetch_pkg::wb_m2s_t     wb_i,
    output fetch_pkg::wb_s2m_t     wb_o,
    input  logic                   enable_i,
    input  logic                   flush_i,
    input  fetch_pkg::redirect_t   branch_i,
    output fetch_pkg::fetch_out_t  out_o
);

    // ==============================
    // interconnect
    // ==============================
    fetch_pkg::imem_wr_t imem_wr;
    logic run;
    logic [31:0] boot_pc;
    // fetch read port
    logic rd_en;
    logic [fetch_pkg::IMEM_AW-1:0] rd_addr;
    logic [31:0] rd_data;
    // queue to stage
    fetch_pkg::redirect_t redirect;
    logic [1:0] drain;
    logic [31:0] head;
    logic [2:0] count;
    logic [31:0] head_pc;

    // bus slave, loader and run control
    fetch_ctrl_regs fetch_ctrl_regs_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .wb_i      (wb_i),
        .wb_o      (wb_o),
        .fill_i    (count),
        .imem_wr_o (imem_wr),
        .run_o     (run),
        .boot_pc_o (boot_pc)
    );

    fetch_imem fetch_imem_i (
        .clk       (clk),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .wr_i      (imem_wr)
    );

    fetch_halfword_fifo fetch_halfword_fifo_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .redirect_i  (redirect),
        .drain_i     (drain),
        .mem_rd_en_o (rd_en),
        .mem_addr_o  (rd_addr),
        .mem_data_i  (rd_data),
        .head_o      (head),
        .count_o     (count),
        .head_pc_o   (head_pc)
    );

    // decode side
    fetch_stage fetch_stage_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .run_i      (run),
        .boot_pc_i  (boot_pc),
        .enable_i   (enable_i),
        .flush_i    (flush_i),
        .branch_i   (branch_i),
        .head_i     (head),
        .count_i    (count),
        .head_pc_i  (head_pc),
        .redirect_o (redirect),
        .drain_o    (drain),
        .out_o      (out_o)
    );

endmodule

// ==== test/fetch_clk_gen.sv ====
module fetch_clk_gen (
    output logic clk,
    output logic reset_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // reset held for 8 rising edges, released just after the edge
    initial begin
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        #10 reset_i = 1'b0;
    end

endmodule

// ==== test/fetch_tb.sv ====
module fetch_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ==============================
    // test sizes
    // ==============================
    localparam int PROG_HW     = 2 ** (fetch_pkg::IMEM_AW + 1);
    localparam int LOAD_WORDS  = 2 ** fetch_pkg::IMEM_AW;
    localparam logic [31:0] REG_BASE = 32'h1 << fetch_pkg::WB_REG_SPACE;
    localparam int N_SEQ       = 300;
    localparam int N_ODD       = 20;
    localparam int N_BR        = 40;
    localparam int N_STALL     = 60;
    localparam int N_FLUSH     = 60;
    // worst case instruction count over all sections
    localparam int TOTAL_INSTR = N_SEQ + N_ODD + N_BR * 8 + N_STALL * 4 + N_FLUSH * 4;
    // bus load takes about 3 cycles a word
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 10 + LOAD_WORDS * 4 + 2000;

    logic clk;
    logic reset_i;
    fetch_pkg::wb_m2s_t wb;
    fetch_pkg::wb_s2m_t wb_o;
    logic enable_i;
    logic flush_i;
    fetch_pkg::redirect_t branch;
    fetch_pkg::fetch_out_t dout;

    // program image with one entry per halfword
    logic [15:0] prog [PROG_HW];
    integer seed;
    // tb side view of the run bit
    logic running;
    logic [31:0] exp_pc;
    int consumed;

    fetch_clk_gen fetch_clk_gen_i (
        .clk     (clk),
        .reset_i (reset_i)
    );

    fetch_top fetch_top_i (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_i     (wb),
        .wb_o     (wb_o),
        .enable_i (enable_i),
        .flush_i  (flush_i),
        .branch_i (branch),
        .out_o    (dout)
    );

    // ==============================
    // reporting
    // ==============================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("Mismatch at %0t ns: %s got %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    // ==============================
    // reference model
    // ==============================
    // expected instruction at pc
    // compressed unless low bits are 11
    function automatic fetch_pkg::fetch_out_t expect_at(input logic [31:0] pc);
        fetch_pkg::fetch_out_t e;
        logic [fetch_pkg::IMEM_AW:0] idx;
        logic [15:0] lo;
        logic [15:0] hi;
        idx = pc[fetch_pkg::IMEM_AW+1:1];
        lo = prog[idx];
        // upper half wraps around the end of memory
        hi = prog[idx + 1'b1];
        e.valid = 1'b1;
        e.pc = pc;
        e.compressed = (lo[1:0] != 2'b11);
        e.instr = e.compressed ? {16'd0, lo} : {hi, lo};
        return e;
    endfunction

    // next 32 bit instruction whose low half sits in the upper half of a word
    function automatic logic [31:0] find_straddle(input logic [31:0] from);
        logic [31:0] pc;
        pc = {20'd0, from[11:2], 2'b10};
        while (prog[pc[fetch_pkg::IMEM_AW+1:1]][1:0] != 2'b11) begin
            pc = (pc + 32'd4) & 32'hFFF;
        end
        return pc;
    endfunction

    // random mix of 16 and 32 bit instructions
    task automatic build_program();
        int i;
        logic [31:0] r;
        logic [31:0] pick;
        i = 0;
        while (i < PROG_HW) begin
            pick = $random(seed);
            r = $random(seed);
            if (pick[0] && i < PROG_HW - 1) begin
                prog[i] = {r[15:2], 2'b11};
                prog[i+1] = r[31:16];
                i = i + 2;
            end else begin
                prog[i] = r[15:0];
                // keep it compressed
                if (r[1:0] == 2'b11) begin
                    prog[i][1:0] = 2'b01;
                end
                i = i + 1;
            end
        end
    endtask

    // ==============================
    // bus and stream helpers
    // ==============================
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // returns 10 ns after the edge that follows the ack
    task automatic wait_ack();
        do begin
            @(negedge clk);
        end while (wb_o.ack !== 1'b1);
        next_cycle();
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat);
        wb.cyc = 1'b1;
        wb.stb = 1'b1;
        wb.we  = 1'b1;
        wb.adr = adr;
        wb.dat = dat;
        wb.sel = 4'hF;
        wait_ack();
        wb = '0;
        // stb low for one edge ends the access
        next_cycle();
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [31:0] dat);
        wb.cyc = 1'b1;
        wb.stb = 1'b1;
        wb.we  = 1'b0;
        wb.adr = adr;
        wb.sel = 4'hF;
        wait_ack();
        dat = wb_o.dat;
        wb = '0;
        // stb low for one edge ends the access
        next_cycle();
    endtask

    task automatic start_run(input logic [31:0] pc);
        bus_write(REG_BASE + 32'd4, pc);
        exp_pc = pc;
        running = 1'b1;
        bus_write(REG_BASE, 32'd1);
    endtask

    task automatic stop_run();
        bus_write(REG_BASE, 32'd0);
        running = 1'b0;
    endtask

    // let n more instructions go to decode
    task automatic run_for(input int n);
        int target;
        target = consumed + n;
        while (consumed < target) begin
            next_cycle();
        end
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        seed = 28499;
        wb = '0;
        enable_i = 1'b1;
        flush_i = 1'b0;
        branch = '0;
        running = 1'b0;
        exp_pc = '0;
        consumed = 0;
        build_program();
        wait (reset_i === 1'b0);
        next_cycle();

        // register readback
        bus_write(REG_BASE + 32'd4, 32'h0000_0A5C);
        bus_read(REG_BASE + 32'd4, rd);
        check_value("boot pc readback", rd, 32'h0000_0A5C);
        bus_write(REG_BASE, 32'd0);
        bus_read(REG_BASE, rd);
        check_value("ctrl readback", rd, 32'd0);

        for (int w = 0; w < LOAD_WORDS; w++) begin
            bus_write(w * 4, {prog[2*w+1], prog[2*w]});
        end
        // nothing valid while stopped
        repeat (20) next_cycle();

        // aligned start with a straight stream
        start_run(32'h0000_0100);
        bus_read(REG_BASE, rd);
        check_value("ctrl run readback", rd, 32'd1);
        bus_read(REG_BASE + 32'd8, rd);
        check_value("status running", {31'd0, rd[0]}, 32'd1);
        run_for(N_SEQ);

        // restart on an odd halfword inside a straddling instruction
        stop_run();
        repeat (5) next_cycle();
        start_run(find_straddle(32'h0000_0300));
        run_for(N_ODD);

        // taken branches to random and straddling targets
        for (int k = 0; k < N_BR; k++) begin
            r = $random(seed);
            run_for(1 + int'(r[2:0]));
            branch.valid = 1'b1;
            branch.pc = k[0] ? find_straddle({20'd0, r[15:4]}) : {20'd0, r[15:5], 1'b0};
            next_cycle();
            branch = '0;
        end

        // stall stretches
        for (int k = 0; k < N_STALL; k++) begin
            r = $random(seed);
            run_for(1 + int'(r[1:0]));
            enable_i = 1'b0;
            repeat (1 + int'(r[4:2])) next_cycle();
            enable_i = 1'b1;
        end

        // flush stretches
        for (int k = 0; k < N_FLUSH; k++) begin
            r = $random(seed);
            run_for(1 + int'(r[1:0]));
            flush_i = 1'b1;
            repeat (1 + int'(r[3:2])) next_cycle();
            flush_i = 1'b0;
        end

        $display("TB PASSED");
        $finish;
    end

    // ==============================
    // comparison
    // ==============================
    // sampled mid cycle while inputs are settled
    initial begin
        fetch_pkg::fetch_out_t exp;
        fetch_pkg::fetch_out_t prev;
        logic prev_hold;
        prev_hold = 1'b0;
        prev = '0;
        wait (reset_i === 1'b0);
        forever begin
            @(negedge clk);
            if (dout.valid !== 1'b0 && dout.valid !== 1'b1) begin
                fail_run("output valid is unknown");
            end
            if (dout.valid === 1'b1 && !running) begin
                fail_run("output became valid while run is clear");
            end
            if (running && flush_i && dout.valid !== 1'b1) begin
                fail_run("no valid NOP output while flush is high");
            end
            if (dout.valid === 1'b1) begin
                // head must not move after a stall cycle
                if (prev_hold && !flush_i) begin
                    check_value("held pc", dout.pc, prev.pc);
                    check_value("held instr", dout.instr, prev.instr);
                end
                exp = expect_at(exp_pc);
                check_value("pc", dout.pc, exp_pc);
                if (flush_i) begin
                    check_value("flush instr", dout.instr, fetch_pkg::NOP_INSTR);
                end else begin
                    check_value("instr", dout.instr, exp.instr);
                    check_value("compressed", {31'd0, dout.compressed},
                                {31'd0, exp.compressed});
                    // taken at the coming edge
                    if (enable_i) begin
                        exp_pc = exp_pc + (exp.compressed ? 32'd2 : 32'd4);
                        consumed = consumed + 1;
                    end
                end
            end else if (prev_hold && !branch.valid) begin
                fail_run("output dropped during a stall");
            end
            prev_hold = (dout.valid === 1'b1) && !enable_i && !flush_i && !branch.valid;
            prev = dout;
            if (branch.valid) begin
                exp_pc = branch.pc;
            end
        end
    end

    // ==============================
    // watchdog
    // ==============================
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("watchdog expired before all tests finished");
    end

endmodule
